//--- design/axil_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axil_arbiter (
	input  wire                    clk,
	input  wire                    rst,
	// master 0, instruction fetch
	input  wire                    m0_awvalid,
	output logic                   m0_awready,
	input  wire mem_pkg::axil_aw_t m0_aw,
	input  wire                    m0_wvalid,
	output logic                   m0_wready,
	input  wire mem_pkg::axil_w_t  m0_w,
	output logic                   m0_bvalid,
	input  wire                    m0_bready,
	output mem_pkg::axil_b_t       m0_b,
	input  wire                    m0_arvalid,
	output logic                   m0_arready,
	input  wire mem_pkg::axil_ar_t m0_ar,
	output logic                   m0_rvalid,
	input  wire                    m0_rready,
	output mem_pkg::axil_r_t       m0_r,
	// master 1, load/store
	input  wire                    m1_awvalid,
	output logic                   m1_awready,
	input  wire mem_pkg::axil_aw_t m1_aw,
	input  wire                    m1_wvalid,
	output logic                   m1_wready,
	input  wire mem_pkg::axil_w_t  m1_w,
	output logic                   m1_bvalid,
	input  wire                    m1_bready,
	output mem_pkg::axil_b_t       m1_b,
	input  wire                    m1_arvalid,
	output logic                   m1_arready,
	input  wire mem_pkg::axil_ar_t m1_ar,
	output logic                   m1_rvalid,
	input  wire                    m1_rready,
	output mem_pkg::axil_r_t       m1_r,
	// shared slave
	output logic                   s_awvalid,
	input  wire                    s_awready,
	output mem_pkg::axil_aw_t      s_aw,
	output logic                   s_wvalid,
	input  wire                    s_wready,
	output mem_pkg::axil_w_t       s_w,
	input  wire                    s_bvalid,
	output logic                   s_bready,
	input  wire mem_pkg::axil_b_t  s_b,
	output logic                   s_arvalid,
	input  wire                    s_arready,
	output mem_pkg::axil_ar_t      s_ar,
	input  wire                    s_rvalid,
	output logic                   s_rready,
	input  wire mem_pkg::axil_r_t  s_r
);

	mem_pkg::arb_state_e rd_state, wr_state;
	mem_pkg::arb_state_e rd_grant, wr_grant;
	// last winner per channel, 1 means master 1
	logic rd_last, wr_last;
	logic m0_wr_req, m1_wr_req;

	// round robin pick, loser of last contest wins a tie
	function automatic mem_pkg::arb_state_e pick_grant(input logic req0, input logic req1,
			input logic last);
		if (req0 && req1)
			return last ? mem_pkg::BUSY_M0 : mem_pkg::BUSY_M1;
		else if (req0)
			return mem_pkg::BUSY_M0;
		else if (req1)
			return mem_pkg::BUSY_M1;
		return mem_pkg::IDLE;
	endfunction

	// write needs address and data together
	assign m0_wr_req = m0_awvalid && m0_wvalid;
	assign m1_wr_req = m1_awvalid && m1_wvalid;

	assign rd_grant = pick_grant(m0_arvalid, m1_arvalid, rd_last);
	assign wr_grant = pick_grant(m0_wr_req, m1_wr_req, wr_last);

	// read channel fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= mem_pkg::IDLE;
			rd_last  <= 1'b1;
		end else begin
			case (rd_state)
				mem_pkg::IDLE: begin
					rd_state <= rd_grant;
					if (rd_grant != mem_pkg::IDLE)
						rd_last <= (rd_grant == mem_pkg::BUSY_M1);
				end
				// release on the r beat at the winner
				mem_pkg::BUSY_M0: if (m0_rvalid && m0_rready) rd_state <= mem_pkg::IDLE;
				mem_pkg::BUSY_M1: if (m1_rvalid && m1_rready) rd_state <= mem_pkg::IDLE;
				default: rd_state <= mem_pkg::IDLE;
			endcase
		end
	end

	// write channel fsm, same shape
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= mem_pkg::IDLE;
			wr_last  <= 1'b1;
		end else begin
			case (wr_state)
				mem_pkg::IDLE: begin
					wr_state <= wr_grant;
					if (wr_grant != mem_pkg::IDLE)
						wr_last <= (wr_grant == mem_pkg::BUSY_M1);
				end
				mem_pkg::BUSY_M0: if (m0_bvalid && m0_bready) wr_state <= mem_pkg::IDLE;
				mem_pkg::BUSY_M1: if (m1_bvalid && m1_bready) wr_state <= mem_pkg::IDLE;
				default: wr_state <= mem_pkg::IDLE;
			endcase
		end
	end

	// read path mux, everything low while idle
	always_comb begin
		s_arvalid  = 1'b0;
		s_ar       = m0_ar;
		s_rready   = 1'b0;
		m0_arready = 1'b0;
		m1_arready = 1'b0;
		m0_rvalid  = 1'b0;
		m1_rvalid  = 1'b0;
		m0_r       = '0;
		m1_r       = '0;
		case (rd_state)
			mem_pkg::BUSY_M0: begin
				s_arvalid  = m0_arvalid;
				s_rready   = m0_rready;
				m0_arready = s_arready;
				m0_rvalid  = s_rvalid;
				m0_r       = s_r;
			end
			mem_pkg::BUSY_M1: begin
				s_arvalid  = m1_arvalid;
				s_ar       = m1_ar;
				s_rready   = m1_rready;
				m1_arready = s_arready;
				m1_rvalid  = s_rvalid;
				m1_r       = s_r;
			end
			default: ;
		endcase
	end

	// write path mux, aw and w follow the same grant
	always_comb begin
		s_awvalid  = 1'b0;
		s_aw       = m0_aw;
		s_wvalid   = 1'b0;
		s_w        = m0_w;
		s_bready   = 1'b0;
		m0_awready = 1'b0;
		m1_awready = 1'b0;
		m0_wready  = 1'b0;
		m1_wready  = 1'b0;
		m0_bvalid  = 1'b0;
		m1_bvalid  = 1'b0;
		m0_b       = '0;
		m1_b       = '0;
		case (wr_state)
			mem_pkg::BUSY_M0: begin
				s_awvalid  = m0_awvalid;
				s_wvalid   = m0_wvalid;
				s_bready   = m0_bready;
				m0_awready = s_awready;
				m0_wready  = s_wready;
				m0_bvalid  = s_bvalid;
				m0_b       = s_b;
			end
			mem_pkg::BUSY_M1: begin
				s_awvalid  = m1_awvalid;
				s_aw       = m1_aw;
				s_wvalid   = m1_wvalid;
				s_w        = m1_w;
				s_bready   = m1_bready;
				m1_awready = s_awready;
				m1_wready  = s_wready;
				m1_bvalid  = s_bvalid;
				m1_b       = s_b;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// one strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;

	// axi response codes, exokay and decerr unused
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// write address channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axil_aw_t;

	// write data channel payload
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axil_w_t;

	// read address channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axil_ar_t;

	// read data channel payload
	typedef struct packed {
		logic [DATA_W-1:0] data;
		axil_resp_e        resp;
	} axil_r_t;

	// write response channel payload
	typedef struct packed {
		axil_resp_e resp;
	} axil_b_t;

	// per-channel arbiter state, busy names the granted master
	typedef enum logic [1:0] {
		IDLE,
		BUSY_M0,
		BUSY_M1
	} arb_state_e;

	// memory write side
	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} sram_wr_state_e;

	// memory read side
	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} sram_rd_state_e;

endpackage

`default_nettype wire

//--- design/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
	parameter int unsigned MEM_WORDS = 256
) (
	input  wire                    clk,
	input  wire                    rst,
	// master 0, instruction fetch
	input  wire                    m0_awvalid,
	output logic                   m0_awready,
	input  wire mem_pkg::axil_aw_t m0_aw,
	input  wire                    m0_wvalid,
	output logic                   m0_wready,
	input  wire mem_pkg::axil_w_t  m0_w,
	output logic                   m0_bvalid,
	input  wire                    m0_bready,
	output mem_pkg::axil_b_t       m0_b,
	input  wire                    m0_arvalid,
	output logic                   m0_arready,
	input  wire mem_pkg::axil_ar_t m0_ar,
	output logic                   m0_rvalid,
	input  wire                    m0_rready,
	output mem_pkg::axil_r_t       m0_r,
	// master 1, load/store
	input  wire                    m1_awvalid,
	output logic                   m1_awready,
	input  wire mem_pkg::axil_aw_t m1_aw,
	input  wire                    m1_wvalid,
	output logic                   m1_wready,
	input  wire mem_pkg::axil_w_t  m1_w,
	output logic                   m1_bvalid,
	input  wire                    m1_bready,
	output mem_pkg::axil_b_t       m1_b,
	input  wire                    m1_arvalid,
	output logic                   m1_arready,
	input  wire mem_pkg::axil_ar_t m1_ar,
	output logic                   m1_rvalid,
	input  wire                    m1_rready,
	output mem_pkg::axil_r_t       m1_r
);

	// arbiter to memory, single slave port
	logic              s_awvalid, s_awready;
	mem_pkg::axil_aw_t s_aw;
	logic              s_wvalid, s_wready;
	mem_pkg::axil_w_t  s_w;
	logic              s_bvalid, s_bready;
	mem_pkg::axil_b_t  s_b;
	logic              s_arvalid, s_arready;
	mem_pkg::axil_ar_t s_ar;
	logic              s_rvalid, s_rready;
	mem_pkg::axil_r_t  s_r;

	// separate read and write arbitration
	axil_arbiter arb_i (
		.clk        (clk),
		.rst        (rst),
		.m0_awvalid (m0_awvalid),
		.m0_awready (m0_awready),
		.m0_aw      (m0_aw),
		.m0_wvalid  (m0_wvalid),
		.m0_wready  (m0_wready),
		.m0_w       (m0_w),
		.m0_bvalid  (m0_bvalid),
		.m0_bready  (m0_bready),
		.m0_b       (m0_b),
		.m0_arvalid (m0_arvalid),
		.m0_arready (m0_arready),
		.m0_ar      (m0_ar),
		.m0_rvalid  (m0_rvalid),
		.m0_rready  (m0_rready),
		.m0_r       (m0_r),
		.m1_awvalid (m1_awvalid),
		.m1_awready (m1_awready),
		.m1_aw      (m1_aw),
		.m1_wvalid  (m1_wvalid),
		.m1_wready  (m1_wready),
		.m1_w       (m1_w),
		.m1_bvalid  (m1_bvalid),
		.m1_bready  (m1_bready),
		.m1_b       (m1_b),
		.m1_arvalid (m1_arvalid),
		.m1_arready (m1_arready),
		.m1_ar      (m1_ar),
		.m1_rvalid  (m1_rvalid),
		.m1_rready  (m1_rready),
		.m1_r       (m1_r),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_aw       (s_aw),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_w        (s_w),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_b        (s_b),
		.s_arvalid  (s_arvalid),
		.s_arready  (s_arready),
		.s_ar       (s_ar),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.s_r        (s_r)
	);

	// memory size set here
	sram_slave #(
		.MEM_WORDS (MEM_WORDS)
	) mem_i (
		.clk     (clk),
		.rst     (rst),
		.awvalid (s_awvalid),
		.awready (s_awready),
		.aw      (s_aw),
		.wvalid  (s_wvalid),
		.wready  (s_wready),
		.w       (s_w),
		.bvalid  (s_bvalid),
		.bready  (s_bready),
		.b       (s_b),
		.arvalid (s_arvalid),
		.arready (s_arready),
		.ar      (s_ar),
		.rvalid  (s_rvalid),
		.rready  (s_rready),
		.r       (s_r)
	);

endmodule

`default_nettype wire

//--- design/sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
	parameter int unsigned MEM_WORDS = 256
) (
	input  wire                    clk,
	input  wire                    rst,
	// write address and data
	input  wire                    awvalid,
	output logic                   awready,
	input  wire mem_pkg::axil_aw_t aw,
	input  wire                    wvalid,
	output logic                   wready,
	input  wire mem_pkg::axil_w_t  w,
	// write response
	output logic                   bvalid,
	input  wire                    bready,
	output mem_pkg::axil_b_t       b,
	// read address
	input  wire                    arvalid,
	output logic                   arready,
	input  wire mem_pkg::axil_ar_t ar,
	// read data
	output logic                   rvalid,
	input  wire                    rready,
	output mem_pkg::axil_r_t       r
);

	// byte address minus the 3 offset bits
	localparam int IDX_W = mem_pkg::ADDR_W - 3;
	// bits needed to index the array itself
	localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [mem_pkg::DATA_W-1:0] mem [MEM_WORDS];

	mem_pkg::sram_wr_state_e wr_state;
	mem_pkg::sram_rd_state_e rd_state;

	logic [IDX_W-1:0] wr_idx, rd_idx;
	logic             wr_in_range, rd_in_range;
	logic             wr_fire, rd_fire;

	assign wr_idx = aw.addr[mem_pkg::ADDR_W-1:3];
	assign rd_idx = ar.addr[mem_pkg::ADDR_W-1:3];

	// beyond the array means slverr
	assign wr_in_range = 32'(wr_idx) < MEM_WORDS;
	assign rd_in_range = 32'(rd_idx) < MEM_WORDS;

	// ready only while idle
	assign awready = (wr_state == mem_pkg::WR_IDLE);
	assign wready  = (wr_state == mem_pkg::WR_IDLE);
	assign arready = (rd_state == mem_pkg::RD_IDLE);

	// write needs both aw and w in the same cycle
	assign wr_fire = awready && awvalid && wready && wvalid;
	assign rd_fire = arready && arvalid;

	assign bvalid = (wr_state == mem_pkg::WR_RESP);
	assign rvalid = (rd_state == mem_pkg::RD_RESP);

	// write fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= mem_pkg::WR_IDLE;
		end else begin
			case (wr_state)
				mem_pkg::WR_IDLE: if (wr_fire) wr_state <= mem_pkg::WR_RESP;
				// hold b until master takes it
				mem_pkg::WR_RESP: if (bready) wr_state <= mem_pkg::WR_IDLE;
				default: wr_state <= mem_pkg::WR_IDLE;
			endcase
		end
	end

	// write response code, captured with the write
	always_ff @(posedge clk) begin
		if (wr_fire)
			b.resp <= wr_in_range ? mem_pkg::OKAY : mem_pkg::SLVERR;
	end

	// strobed byte write into the array
	always_ff @(posedge clk) begin
		if (wr_fire && wr_in_range) begin
			for (int i = 0; i < mem_pkg::STRB_W; i++) begin
				if (w.strb[i])
					mem[wr_idx[MEM_AW-1:0]][i*8 +: 8] <= w.data[i*8 +: 8];
			end
		end
	end

	// read fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= mem_pkg::RD_IDLE;
		end else begin
			case (rd_state)
				mem_pkg::RD_IDLE: if (rd_fire) rd_state <= mem_pkg::RD_RESP;
				mem_pkg::RD_RESP: if (rready) rd_state <= mem_pkg::RD_IDLE;
				default: rd_state <= mem_pkg::RD_IDLE;
			endcase
		end
	end

	// registered read word, zero on a miss
	// payload stays put while rvalid waits on rready
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			if (rd_in_range) begin
				r.data <= mem[rd_idx[MEM_AW-1:0]];
				r.resp <= mem_pkg::OKAY;
			end else begin
				r.data <= '0;
				r.resp <= mem_pkg::SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

	// local copy of the memory size
	localparam int unsigned MEM_WORDS = 256;
	localparam int TIMEOUT = 50;
	localparam int N_TXN = 18;
	// handshake kinds for the wait loop
	localparam int K_AR = 0;
	localparam int K_W  = 1;
	localparam int K_R  = 2;
	localparam int K_B  = 3;

	// read with write means the other master writes addr + 8
	typedef enum logic [1:0] {
		OP_RD,
		OP_WR,
		OP_RD_WR,
		OP_RD_RD
	} op_e;

	typedef struct packed {
		logic        m;
		op_e         op;
		logic [31:0] addr;
		logic [7:0]  strb;
		logic [3:0]  hold;
	} txn_t;

	logic clk;
	logic rst;

	// master side inputs indexed by master
	logic [1:0]        awvalid, wvalid, bready, arvalid, rready;
	mem_pkg::axil_aw_t aw [2];
	mem_pkg::axil_w_t  w [2];
	mem_pkg::axil_ar_t ar [2];

	// master side outputs
	wire [1:0]        awready, wready, bvalid, arready, rvalid;
	wire mem_pkg::axil_b_t b0, b1;
	wire mem_pkg::axil_r_t r0, r1;

	// reference memory
	logic [63:0] ref_mem [MEM_WORDS];
	txn_t        tbl [N_TXN];

	mem_subsys #(
		.MEM_WORDS (MEM_WORDS)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.m0_awvalid (awvalid[0]),
		.m0_awready (awready[0]),
		.m0_aw      (aw[0]),
		.m0_wvalid  (wvalid[0]),
		.m0_wready  (wready[0]),
		.m0_w       (w[0]),
		.m0_bvalid  (bvalid[0]),
		.m0_bready  (bready[0]),
		.m0_b       (b0),
		.m0_arvalid (arvalid[0]),
		.m0_arready (arready[0]),
		.m0_ar      (ar[0]),
		.m0_rvalid  (rvalid[0]),
		.m0_rready  (rready[0]),
		.m0_r       (r0),
		.m1_awvalid (awvalid[1]),
		.m1_awready (awready[1]),
		.m1_aw      (aw[1]),
		.m1_wvalid  (wvalid[1]),
		.m1_wready  (wready[1]),
		.m1_w       (w[1]),
		.m1_bvalid  (bvalid[1]),
		.m1_bready  (bready[1]),
		.m1_b       (b1),
		.m1_arvalid (arvalid[1]),
		.m1_arready (arready[1]),
		.m1_ar      (ar[1]),
		.m1_rvalid  (rvalid[1]),
		.m1_rready  (rready[1]),
		.m1_r       (r1)
	);

	// handshake checks inside the memory
	bind sram_slave sram_slave_checker chk_i (
		.clk    (clk),
		.rst    (rst),
		.rvalid (rvalid),
		.rready (rready),
		.r      (r),
		.bvalid (bvalid),
		.bready (bready),
		.b      (b)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic mem_pkg::axil_r_t resp_r(input int m);
		return (m != 0) ? r1 : r0;
	endfunction

	function automatic mem_pkg::axil_b_t resp_b(input int m);
		return (m != 0) ? b1 : b0;
	endfunction

	function automatic logic flag(input int kind, input int m);
		case (kind)
			K_AR: return arready[m];
			// write accepted only with aw and w together
			K_W:  return awready[m] && wready[m];
			K_R:  return rvalid[m];
			default: return bvalid[m];
		endcase
	endfunction

	// expected read beat from the reference and the range rule
	function automatic mem_pkg::axil_r_t expect_read(input logic [31:0] addr);
		mem_pkg::axil_r_t e;
		if ((addr >> 3) < MEM_WORDS) begin
			e.data = ref_mem[addr >> 3];
			e.resp = mem_pkg::OKAY;
		end else begin
			e.data = '0;
			e.resp = mem_pkg::SLVERR;
		end
		return e;
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb);
		if ((addr >> 3) < MEM_WORDS) begin
			for (int i = 0; i < 8; i++) begin
				if (strb[i])
					ref_mem[addr >> 3][8*i +: 8] = data[8*i +: 8];
			end
		end
	endtask

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	// a failed assertion in the bound checker ends the run
	always @(negedge clk) begin
		if (dut_i.mem_i.chk_i.fail_cnt != 0) begin
			$display("a handshake assertion inside the memory failed at %0t", $time);
			abort_run();
		end
	end

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_r(input mem_pkg::axil_r_t got, input mem_pkg::axil_r_t exp);
		if (got.data !== exp.data) begin
			$display("mismatch at %0t: r.data is %h, expected %h", $time, got.data, exp.data);
			abort_run();
		end
		if (got.resp !== exp.resp) begin
			$display("mismatch at %0t: r.resp is %b, expected %b", $time, got.resp, exp.resp);
			abort_run();
		end
	endtask

	task automatic check_b(input mem_pkg::axil_b_t got, input mem_pkg::axil_b_t exp);
		if (got.resp !== exp.resp) begin
			$display("mismatch at %0t: b.resp is %b, expected %b", $time, got.resp, exp.resp);
			abort_run();
		end
	endtask

	// sampled on the falling edge
	// cycles spent waiting come back in cycles
	task automatic wait_flag(input int kind, input int m, input string what, output int cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (!flag(kind, m)) begin
			n++;
			if (n >= TIMEOUT) begin
				$display("timeout at %0t: %s on master %0d never arrived", $time, what, m);
				abort_run();
			end
			@(negedge clk);
		end
		cycles = n;
	endtask

	task automatic read_txn(input int m, input logic [31:0] addr, input int hold);
		mem_pkg::axil_r_t exp;
		int n;
		exp = expect_read(addr);
		ar[m].addr = addr;
		arvalid[m] = 1'b1;
		rready[m]  = (hold == 0);
		wait_flag(K_AR, m, "read address handshake", n);
		@(posedge clk);
		#1;
		arvalid[m] = 1'b0;
		wait_flag(K_R, m, "rvalid", n);
		// response one cycle after the address beat
		if (n != 0) begin
			$display("mismatch at %0t: r came %0d cycles late", $time, n);
			abort_run();
		end
		check_r(resp_r(m), exp);
		// stall and release rready on the last stalled cycle
		for (int k = 0; k < hold; k++) begin
			@(posedge clk);
			#1;
			if (k == hold - 1)
				rready[m] = 1'b1;
			@(negedge clk);
			check_bit("rvalid under back-pressure", rvalid[m], 1'b1);
			check_r(resp_r(m), exp);
		end
		@(posedge clk);
		#1;
		rready[m] = 1'b0;
	endtask

	task automatic write_txn(input int m, input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input int hold);
		mem_pkg::axil_b_t exp;
		int n;
		exp.resp = ((addr >> 3) < MEM_WORDS) ? mem_pkg::OKAY : mem_pkg::SLVERR;
		aw[m].addr = addr;
		w[m].data  = data;
		w[m].strb  = strb;
		awvalid[m] = 1'b1;
		wvalid[m]  = 1'b1;
		bready[m]  = (hold == 0);
		wait_flag(K_W, m, "write address and data handshake", n);
		@(posedge clk);
		#1;
		awvalid[m] = 1'b0;
		wvalid[m]  = 1'b0;
		model_write(addr, data, strb);
		wait_flag(K_B, m, "bvalid", n);
		if (n != 0) begin
			$display("mismatch at %0t: b came %0d cycles late", $time, n);
			abort_run();
		end
		check_b(resp_b(m), exp);
		for (int k = 0; k < hold; k++) begin
			@(posedge clk);
			#1;
			if (k == hold - 1)
				bready[m] = 1'b1;
			@(negedge clk);
			check_bit("bvalid under back-pressure", bvalid[m], 1'b1);
			check_b(resp_b(m), exp);
		end
		@(posedge clk);
		#1;
		bready[m] = 1'b0;
	endtask

	initial begin
		txn_t        t;
		logic [63:0] data;
		logic [31:0] rng;

		rng = 32'h2f9;
		rst = 1'b1;
		awvalid = '0;
		wvalid  = '0;
		bready  = '0;
		arvalid = '0;
		rready  = '0;
		for (int i = 0; i < 2; i++) begin
			aw[i] = '0;
			w[i]  = '0;
			ar[i] = '0;
		end

		// master, op, address, strobe, stall cycles
		tbl[0]  = '{1'b0, OP_WR,    32'h0000_0000, 8'hff, 4'd0};
		tbl[1]  = '{1'b0, OP_RD,    32'h0000_0000, 8'h00, 4'd0};
		tbl[2]  = '{1'b1, OP_WR,    32'h0000_0010, 8'hff, 4'd0};
		tbl[3]  = '{1'b1, OP_RD,    32'h0000_0010, 8'h00, 4'd0};
		tbl[4]  = '{1'b0, OP_WR,    32'h0000_0008, 8'hff, 4'd0};
		// partial strobe merge
		tbl[5]  = '{1'b1, OP_WR,    32'h0000_0010, 8'h5a, 4'd0};
		tbl[6]  = '{1'b0, OP_RD,    32'h0000_0010, 8'h00, 4'd0};
		// first word past the array
		tbl[7]  = '{1'b1, OP_WR,    32'h0000_0800, 8'hff, 4'd0};
		tbl[8]  = '{1'b0, OP_RD,    32'h0000_0800, 8'h00, 4'd0};
		tbl[9]  = '{1'b1, OP_RD,    32'h0000_0000, 8'h00, 4'd0};
		tbl[10] = '{1'b0, OP_RD_RD, 32'h0000_0008, 8'h00, 4'd0};
		tbl[11] = '{1'b1, OP_RD_WR, 32'h0000_0000, 8'h0f, 4'd2};
		tbl[12] = '{1'b0, OP_RD,    32'h0000_0008, 8'h00, 4'd3};
		tbl[13] = '{1'b1, OP_WR,    32'h0000_0018, 8'hff, 4'd4};
		tbl[14] = '{1'b1, OP_RD,    32'h0000_0018, 8'h00, 4'd1};
		tbl[15] = '{1'b0, OP_WR,    32'h1000_0000, 8'hff, 4'd1};
		tbl[16] = '{1'b0, OP_RD_WR, 32'h0000_0018, 8'hff, 4'd0};
		tbl[17] = '{1'b1, OP_RD_RD, 32'h0000_0018, 8'h00, 4'd1};

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// master ports quiet right after reset
		@(negedge clk);
		check_bit("awready after reset", |awready, 1'b0);
		check_bit("wready after reset", |wready, 1'b0);
		check_bit("bvalid after reset", |bvalid, 1'b0);
		check_bit("arready after reset", |arready, 1'b0);
		check_bit("rvalid after reset", |rvalid, 1'b0);
		@(posedge clk);
		#1;

		for (int i = 0; i < N_TXN; i++) begin
			t = tbl[i];
			rng = xorshift(rng);
			data[63:32] = rng;
			rng = xorshift(rng);
			data[31:0] = rng;
			case (t.op)
				OP_RD: read_txn(t.m, t.addr, t.hold);
				OP_WR: write_txn(t.m, t.addr, data, t.strb, t.hold);
				// both masters at once with the other one on the next word
				OP_RD_WR: begin
					fork
						read_txn(t.m, t.addr, t.hold);
						write_txn(!t.m, t.addr + 8, data, t.strb, t.hold);
					join
				end
				default: begin
					fork
						read_txn(t.m, t.addr, t.hold);
						read_txn(!t.m, t.addr + 8, t.hold);
					join
				end
			endcase
		end

		if (dut_i.mem_i.chk_i.fail_cnt != 0) begin
			$display("a handshake assertion inside the memory failed");
			abort_run();
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb/sram_slave_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave_checker (
	input wire                   clk,
	input wire                   rst,
	input wire                   rvalid,
	input wire                   rready,
	input wire mem_pkg::axil_r_t r,
	input wire                   bvalid,
	input wire                   bready,
	input wire mem_pkg::axil_b_t b
);

	// failed assertions so far
	int fail_cnt = 0;

	// read data held steady while the master stalls
	r_hold_a: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(r))
		else begin
			$error("r channel dropped or changed before rready");
			fail_cnt++;
		end

	// same for the write response
	b_hold_a: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(b))
		else begin
			$error("b channel dropped or changed before bready");
			fail_cnt++;
		end

	// no response leaves reset
	rst_quiet_a: assert property (@(posedge clk)
		rst |=> !rvalid && !bvalid)
		else begin
			$error("rvalid or bvalid high in the cycle after reset");
			fail_cnt++;
		end

endmodule

`default_nettype wire

//--- vlog.f
design/mem_pkg.sv
design/axil_arbiter.sv
design/sram_slave.sv
design/mem_subsys.sv
tb/sram_slave_checker.sv
tb/mem_subsys_tb.sv
